// File: gfx_stripe_params.svh
// ############################
// build-time settings for the striped framebuffer
// set GFX_MODE_640_480 to 1 for the real video mode
// ############################
`ifndef GFX_STRIPE_PARAMS_SVH
`define GFX_STRIPE_PARAMS_SVH
`default_nettype none

`define GFX_MODE_640_480 0

`define GFX_NUM_S       2
`define GFX_SRAM_ADDR_W 19
`define GFX_SRAM_DATA_W 16
`define GFX_COLOR_W     4
`define GFX_FIFO_DEPTH  8
`define GFX_APB_ADDR_W  8
`define GFX_APB_DATA_W  32

// horizontal in pixels, vertical in lines
`define GFX_H_VISIBLE (`GFX_MODE_640_480 ? 640 : 32)
`define GFX_H_FRONT   (`GFX_MODE_640_480 ? 16 : 4)
`define GFX_H_SYNC    (`GFX_MODE_640_480 ? 96 : 4)
`define GFX_H_BACK    (`GFX_MODE_640_480 ? 48 : 8)
`define GFX_V_VISIBLE (`GFX_MODE_640_480 ? 480 : 8)
`define GFX_V_FRONT   (`GFX_MODE_640_480 ? 10 : 1)
`define GFX_V_SYNC    (`GFX_MODE_640_480 ? 2 : 1)
`define GFX_V_BACK    (`GFX_MODE_640_480 ? 33 : 2)

`default_nettype wire
`endif

// File: gfx_stripe_pkg.sv
// ############################
// shared types of the graphics subsystem
// import with gfx_stripe_pkg::* in the module header
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

package gfx_stripe_pkg;

  typedef struct packed {
    logic [`GFX_COLOR_W-1:0] red;
    logic [`GFX_COLOR_W-1:0] grn;
    logic [`GFX_COLOR_W-1:0] blu;
  } pixel_t;

  // word address inside one stripe
  typedef logic [`GFX_SRAM_ADDR_W-1:0] fb_addr_t;
  typedef logic [$clog2(`GFX_NUM_S)-1:0] stripe_t;

  // fill level and free space of a FIFO
  typedef logic [$clog2(`GFX_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  typedef struct packed {
    stripe_t  stripe;
    fb_addr_t addr;
    pixel_t   pix;
  } wr_req_t;

  typedef enum logic [`GFX_APB_ADDR_W-1:0] {
    REG_CTRL   = 'h0,
    REG_KEY    = 'h4,
    REG_FRAMES = 'h8,
    REG_ERRS   = 'hC
  } apb_reg_e;

endpackage

`default_nettype wire

// File: vga_timing.sv
// ############################
// vga sync generator, pops one pixel per visible cycle
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module vga_timing
  import gfx_stripe_pkg::*;
(
  input  logic                    pixel_clk,
  input  logic                    rst_n,
  input  logic                    pix_empty,
  input  pixel_t                  pix_data,
  output logic                    pix_pop,
  output logic                    frame_start,
  output logic [`GFX_COLOR_W-1:0] vga_red,
  output logic [`GFX_COLOR_W-1:0] vga_grn,
  output logic [`GFX_COLOR_W-1:0] vga_blu,
  output logic                    vga_hsync,
  output logic                    vga_vsync,
  output logic                    underflow
);
  localparam int H_SYNC_BEG = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int H_SYNC_END = H_SYNC_BEG + `GFX_H_SYNC;
  localparam int H_TOTAL    = H_SYNC_END + `GFX_H_BACK;
  localparam int V_SYNC_BEG = `GFX_V_VISIBLE + `GFX_V_FRONT;
  localparam int V_SYNC_END = V_SYNC_BEG + `GFX_V_SYNC;
  localparam int V_TOTAL    = V_SYNC_END + `GFX_V_BACK;
  localparam int HW         = $clog2(H_TOTAL);
  localparam int VW         = $clog2(V_TOTAL);

  logic [HW-1:0] h_cnt;
  logic [HW-1:0] h_nxt;
  logic [VW-1:0] v_cnt;
  logic [VW-1:0] v_nxt;
  logic          vis_nxt;

  // outputs are registered from the next count, so they line up with h_cnt
  always_comb begin
    h_nxt = h_cnt + 1'b1;
    v_nxt = v_cnt;
    if (h_cnt == HW'(H_TOTAL - 1)) begin
      h_nxt = '0;
      v_nxt = (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
    end
  end

  assign vis_nxt = (h_nxt < `GFX_H_VISIBLE) && (v_nxt < `GFX_V_VISIBLE);
  assign pix_pop = vis_nxt;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      // first step lands on the last back porch line
      h_cnt       <= HW'(H_TOTAL - 1);
      v_cnt       <= VW'(V_TOTAL - 2);
      vga_hsync   <= 1'b1;
      vga_vsync   <= 1'b1;
      vga_red     <= '0;
      vga_grn     <= '0;
      vga_blu     <= '0;
      frame_start <= 1'b0;
      underflow   <= 1'b0;
    end else begin
      h_cnt       <= h_nxt;
      v_cnt       <= v_nxt;
      vga_hsync   <= !((h_nxt >= H_SYNC_BEG) && (h_nxt < H_SYNC_END));
      vga_vsync   <= !((v_nxt >= V_SYNC_BEG) && (v_nxt < V_SYNC_END));
      frame_start <= (h_nxt == '0) && (v_nxt == VW'(V_TOTAL - 1));
      underflow   <= vis_nxt && pix_empty;
      // empty fifo already hands out a zero pixel
      vga_red     <= vis_nxt ? pix_data.red : '0;
      vga_grn     <= vis_nxt ? pix_data.grn : '0;
      vga_blu     <= vis_nxt ? pix_data.blu : '0;
    end
  end

endmodule

`default_nettype wire

// File: pattern_writer.sv
// ############################
// raster-order test pattern source for the framebuffer
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module pattern_writer
  import gfx_stripe_pkg::*;
(
  input  logic    pixel_clk,
  input  logic    rst_n,
  input  logic    wr_enable,
  input  logic    continuous,
  input  pixel_t  key,
  input  logic    req_full,
  output logic    req_push,
  output wr_req_t req_data
);
  localparam int XW    = $clog2(`GFX_H_VISIBLE);
  localparam int YW    = $clog2(`GFX_V_VISIBLE);
  localparam int C     = `GFX_COLOR_W;
  localparam int WORDS = `GFX_H_VISIBLE / `GFX_NUM_S;

  logic [XW-1:0]  x;
  logic [YW-1:0]  y;
  logic           en_q;
  logic           done;
  logic           active;
  logic           last_px;
  logic [3*C-1:0] key_v;

  assign key_v   = key;
  // idle on the enable edge itself while x and y restart
  assign active   = wr_enable && en_q && (continuous || !done);
  assign req_push = active && !req_full;
  assign last_px  = (x == XW'(`GFX_H_VISIBLE - 1)) && (y == YW'(`GFX_V_VISIBLE - 1));

  always_comb begin
    req_data.stripe  = stripe_t'(x % `GFX_NUM_S);
    req_data.addr    = fb_addr_t'(y) * fb_addr_t'(WORDS) + fb_addr_t'(x / `GFX_NUM_S);
    req_data.pix.red = C'(x) ^ key_v[C-1:0];
    req_data.pix.grn = C'(y) ^ key_v[2*C-1:C];
    req_data.pix.blu = (C'(x) + C'(y)) ^ key_v[3*C-1:2*C];
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      x    <= '0;
      y    <= '0;
      en_q <= 1'b0;
      done <= 1'b0;
    end else begin
      en_q <= wr_enable;
      if (wr_enable && !en_q) begin
        x    <= '0;
        y    <= '0;
        done <= 1'b0;
      end else if (req_push) begin
        if (x == XW'(`GFX_H_VISIBLE - 1)) begin
          x <= '0;
          y <= (y == YW'(`GFX_V_VISIBLE - 1)) ? '0 : y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
        if (last_px && !continuous) done <= 1'b1;
      end
      if (continuous) done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: pixel_fifo.sv
// ############################
// show-ahead FIFO, payload chosen per instance
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module pixel_fifo
  import gfx_stripe_pkg::*;
#(
  parameter type payload_t = pixel_t
) (
  input  logic      pixel_clk,
  input  logic      rst_n,
  input  logic      flush,
  input  logic      push,
  input  payload_t  push_data,
  output logic      full,
  input  logic      pop,
  output payload_t  pop_data,
  output logic      empty,
  output fifo_cnt_t room
);
  localparam int DEPTH = `GFX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  payload_t      mem[DEPTH];
  // extra msb tells full from empty
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic [AW:0]   count;

  assign count    = wr_ptr - rd_ptr;
  assign full     = count == (AW + 1)'(DEPTH);
  assign empty    = count == '0;
  assign room     = fifo_cnt_t'(DEPTH) - fifo_cnt_t'(count);
  assign pop_data = empty ? payload_t'('0) : mem[rd_ptr[AW-1:0]];

  always_ff @(posedge pixel_clk) begin
    if (!rst_n || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (push && !full) mem[wr_ptr[AW-1:0]] <= push_data;
  end

endmodule

`default_nettype wire

// File: stripe_sram_ctrl.sv
// ############################
// slot scheduler for display reads and pattern writes
// reads take slot cycle 0, writes fill the rest
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module stripe_sram_ctrl
  import gfx_stripe_pkg::*;
(
  input  logic                                        pixel_clk,
  input  logic                                        rst_n,
  input  logic                                        frame_start,
  input  logic                                        wr_empty,
  input  wr_req_t                                     wr_data,
  output logic                                        wr_pop,
  input  fifo_cnt_t                                   pix_room,
  output logic                                        pix_push,
  output pixel_t                                      pix_data,
  output logic                                        pix_flush,
  output logic [`GFX_NUM_S*`GFX_SRAM_ADDR_W-1:0]      sram_addr,
  output logic [`GFX_NUM_S*`GFX_SRAM_DATA_W-1:0]      sram_wdata,
  input  logic [`GFX_NUM_S*`GFX_SRAM_DATA_W-1:0]      sram_rdata,
  output logic [`GFX_NUM_S-1:0]                       sram_we_n,
  output logic [`GFX_NUM_S-1:0]                       sram_oe_n
);
  localparam int S  = `GFX_NUM_S;
  localparam int AW = `GFX_SRAM_ADDR_W;
  localparam int DW = `GFX_SRAM_DATA_W;
  localparam int PW = $bits(pixel_t);
  localparam int SW = $clog2(S);
  localparam fb_addr_t LAST_WORD = fb_addr_t'(`GFX_H_VISIBLE / S * `GFX_V_VISIBLE - 1);

  logic [SW-1:0]   slot_cnt;
  logic [SW-1:0]   ser_idx;
  logic            ser_busy;
  logic            rd_pend;
  logic            rd_go;
  fifo_cnt_t       inflight;
  fb_addr_t        fetch_addr;
  logic [S*DW-1:0] rd_word;

  // room must also cover pixels already fetched but not yet pushed
  assign rd_go     = !frame_start && (slot_cnt == '0) &&
                     (pix_room >= inflight + fifo_cnt_t'(S));
  assign wr_pop    = !wr_empty && !rd_go;
  assign pix_push  = ser_busy;
  assign pix_data  = pixel_t'(rd_word[ser_idx*DW +: PW]);
  assign pix_flush = frame_start;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      slot_cnt   <= '0;
      ser_idx    <= '0;
      ser_busy   <= 1'b0;
      rd_pend    <= 1'b0;
      inflight   <= '0;
      fetch_addr <= '0;
      sram_oe_n  <= '1;
      sram_we_n  <= '1;
    end else begin
      slot_cnt  <= (slot_cnt == SW'(S - 1)) ? '0 : slot_cnt + 1'b1;
      rd_pend   <= rd_go;
      sram_oe_n <= {S{!rd_go}};
      sram_we_n <= '1;
      if (wr_pop) sram_we_n[wr_data.stripe] <= 1'b0;
      inflight <= inflight + (rd_go ? fifo_cnt_t'(S) : '0) - fifo_cnt_t'(pix_push);
      // serialize the captured word group in stripe order
      if (ser_busy) begin
        ser_idx <= ser_idx + 1'b1;
        if (ser_idx == SW'(S - 1)) ser_busy <= 1'b0;
      end
      if (rd_pend) begin
        ser_busy <= 1'b1;
        ser_idx  <= '0;
      end
      if (rd_go) fetch_addr <= (fetch_addr == LAST_WORD) ? '0 : fetch_addr + 1'b1;
      // new frame drops any fetch still in flight
      if (frame_start) begin
        fetch_addr <= '0;
        inflight   <= '0;
        rd_pend    <= 1'b0;
        ser_busy   <= 1'b0;
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (rd_pend) rd_word <= sram_rdata;
    for (int i = 0; i < S; i++) begin
      if (rd_go) sram_addr[i*AW +: AW] <= fetch_addr;
    end
    if (wr_pop) begin
      sram_addr[wr_data.stripe*AW +: AW]  <= wr_data.addr;
      sram_wdata[wr_data.stripe*DW +: DW] <= DW'(wr_data.pix);
    end
  end

endmodule

`default_nettype wire

// File: gfx_apb_regs.sv
// ############################
// APB register block, no wait states
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module gfx_apb_regs
  import gfx_stripe_pkg::*;
(
  input  logic                       pixel_clk,
  input  logic                       rst_n,
  input  logic [`GFX_APB_ADDR_W-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`GFX_APB_DATA_W-1:0] pwdata,
  output logic [`GFX_APB_DATA_W-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  logic                       frame_start,
  input  logic                       vga_error,
  output logic                       wr_enable,
  output logic                       continuous,
  output pixel_t                     key
);
  localparam int DW = `GFX_APB_DATA_W;

  apb_reg_e      reg_sel;
  logic          mapped;
  logic          wr_acc;
  logic [15:0]   frame_cnt;
  logic [15:0]   err_cnt;
  logic [DW-1:0] rd_mux;

  assign reg_sel = apb_reg_e'(paddr);

  always_comb begin
    mapped = 1'b1;
    rd_mux = '0;
    case (reg_sel)
      REG_CTRL:   rd_mux = DW'({continuous, wr_enable});
      REG_KEY:    rd_mux = DW'(key);
      REG_FRAMES: rd_mux = DW'(frame_cnt);
      REG_ERRS:   rd_mux = DW'(err_cnt);
      default:    mapped = 1'b0;
    endcase
  end

  assign pready  = 1'b1;
  assign pslverr = psel && penable && !mapped;
  assign wr_acc  = psel && penable && pwrite;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      prdata     <= '0;
      wr_enable  <= 1'b0;
      continuous <= 1'b0;
      key        <= '0;
      frame_cnt  <= '0;
      err_cnt    <= '0;
    end else begin
      // read data is sampled in the setup cycle
      if (psel && !penable && !pwrite) prdata <= rd_mux;
      // both counters stick at all ones
      if (frame_start && frame_cnt != '1) frame_cnt <= frame_cnt + 1'b1;
      if (vga_error && err_cnt != '1) err_cnt <= err_cnt + 1'b1;
      if (wr_acc && reg_sel == REG_CTRL) begin
        wr_enable  <= pwdata[0];
        continuous <= pwdata[1];
      end
      if (wr_acc && reg_sel == REG_KEY) key <= pixel_t'(pwdata[$bits(pixel_t)-1:0]);
      if (wr_acc && reg_sel == REG_ERRS) err_cnt <= '0;
    end
  end

endmodule

`default_nettype wire

// File: gfx_stripe_top.sv
// ############################
// striped framebuffer subsystem top, APB in, VGA and SRAM out
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module gfx_stripe_top
  import gfx_stripe_pkg::*;
(
  input  logic                                   pixel_clk,
  input  logic                                   rst_n,
  input  logic [`GFX_APB_ADDR_W-1:0]             paddr,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [`GFX_APB_DATA_W-1:0]             pwdata,
  output logic [`GFX_APB_DATA_W-1:0]             prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output logic [`GFX_NUM_S*`GFX_SRAM_ADDR_W-1:0] sram_addr,
  output logic [`GFX_NUM_S*`GFX_SRAM_DATA_W-1:0] sram_wdata,
  input  logic [`GFX_NUM_S*`GFX_SRAM_DATA_W-1:0] sram_rdata,
  output logic [`GFX_NUM_S-1:0]                  sram_we_n,
  output logic [`GFX_NUM_S-1:0]                  sram_oe_n,
  output logic [`GFX_COLOR_W-1:0]                vga_red,
  output logic [`GFX_COLOR_W-1:0]                vga_grn,
  output logic [`GFX_COLOR_W-1:0]                vga_blu,
  output logic                                   vga_hsync,
  output logic                                   vga_vsync
);
  logic      frame_start;
  logic      underflow;
  logic      wr_enable;
  logic      continuous;
  pixel_t    key;
  logic      req_push;
  logic      req_full;
  wr_req_t   req_data;
  logic      wr_pop;
  logic      wr_empty;
  wr_req_t   wr_data;
  logic      pix_push;
  logic      pix_pop;
  logic      pix_empty;
  logic      pix_flush;
  pixel_t    pix_wdata;
  pixel_t    pix_rdata;
  fifo_cnt_t pix_room;

  gfx_apb_regs u_apb_regs (
    .pixel_clk(pixel_clk), .rst_n(rst_n),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .frame_start(frame_start), .vga_error(underflow),
    .wr_enable(wr_enable), .continuous(continuous), .key(key)
  );

  pattern_writer u_pattern_writer (
    .pixel_clk(pixel_clk), .rst_n(rst_n),
    .wr_enable(wr_enable), .continuous(continuous), .key(key),
    .req_full(req_full), .req_push(req_push), .req_data(req_data)
  );

  // write requests never need flushing
  pixel_fifo #(.payload_t(wr_req_t)) u_wr_fifo (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .flush(1'b0),
    .push(req_push), .push_data(req_data), .full(req_full),
    .pop(wr_pop), .pop_data(wr_data), .empty(wr_empty), .room()
  );

  stripe_sram_ctrl u_sram_ctrl (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .frame_start(frame_start),
    .wr_empty(wr_empty), .wr_data(wr_data), .wr_pop(wr_pop),
    .pix_room(pix_room), .pix_push(pix_push), .pix_data(pix_wdata), .pix_flush(pix_flush),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_rdata(sram_rdata),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n)
  );

  pixel_fifo #(.payload_t(pixel_t)) u_pix_fifo (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .flush(pix_flush),
    .push(pix_push), .push_data(pix_wdata), .full(),
    .pop(pix_pop), .pop_data(pix_rdata), .empty(pix_empty), .room(pix_room)
  );

  vga_timing u_vga_timing (
    .pixel_clk(pixel_clk), .rst_n(rst_n),
    .pix_empty(pix_empty), .pix_data(pix_rdata), .pix_pop(pix_pop),
    .frame_start(frame_start),
    .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .underflow(underflow)
  );

endmodule

`default_nettype wire

// File: sram_model.sv
// ############################
// async SRAM stripe model for the testbench
// combinational read, level-sensitive write
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module sram_model (
  input  logic [`GFX_SRAM_ADDR_W-1:0] addr,
  input  logic [`GFX_SRAM_DATA_W-1:0] wdata,
  output logic [`GFX_SRAM_DATA_W-1:0] rdata,
  input  logic                        we_n,
  input  logic                        oe_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW = `GFX_SRAM_ADDR_W;
  localparam int DW = `GFX_SRAM_DATA_W;

  logic [DW-1:0] mem[2**AW];

  // fill depends on all address bits so stale reads stand out
  initial begin
    for (int i = 0; i < 2**AW; i++) mem[i] = DW'(i) ^ DW'(i >> 7) ^ 16'ha5c3;
  end

  // settle past the clock edge before writing
  always @(addr or wdata or we_n) begin
    #1;
    if (!we_n) mem[addr] = wdata;
  end

  assign rdata = oe_n ? '0 : mem[addr];

endmodule

`default_nettype wire

// File: gfx_stripe_checker.sv
// ############################
// protocol assertions, bound into the subsystem top
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module gfx_stripe_checker (
  input logic                  pixel_clk,
  input logic                  rst_n,
  input logic [`GFX_NUM_S-1:0] sram_we_n,
  input logic [`GFX_NUM_S-1:0] sram_oe_n,
  input logic                  pready,
  input logic                  vga_hsync
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_SYNC = `GFX_H_SYNC;

  // a stripe never drives and reads at once
  a_no_we_oe: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (~sram_we_n & ~sram_oe_n) == '0)
    else $error("sram we_n and oe_n both low on one stripe");

  a_pready: assert property (@(posedge pixel_clk) disable iff (!rst_n) pready)
    else $error("pready dropped low");

  a_hsync_len: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $fell(vga_hsync) |-> (!vga_hsync)[*H_SYNC] ##1 vga_hsync)
    else $error("hsync pulse length wrong");

endmodule

bind gfx_stripe_top gfx_stripe_checker u_checker (.*);

`default_nettype wire

// File: gfx_stripe_tb.sv
// ############################
// directed testbench for the striped framebuffer
// scans the VGA output against the pattern rule
// ############################
`include "gfx_stripe_params.svh"
`default_nettype none

module gfx_stripe_tb
  import gfx_stripe_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int S          = `GFX_NUM_S;
  localparam int AW         = `GFX_SRAM_ADDR_W;
  localparam int DW         = `GFX_SRAM_DATA_W;
  localparam int H_SYNC_BEG = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int H_TOTAL    = H_SYNC_BEG + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int V_TOTAL    = `GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK;
  localparam int H_WAIT     = `GFX_H_SYNC + `GFX_H_BACK;
  localparam time WD_TIME   = 20 * H_TOTAL * V_TOTAL * 100;

  logic                             pixel_clk;
  logic                             rst_n;
  logic [`GFX_APB_ADDR_W-1:0]       paddr;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [`GFX_APB_DATA_W-1:0]       pwdata;
  logic [`GFX_APB_DATA_W-1:0]       prdata;
  logic                             pready;
  logic                             pslverr;
  logic [S*AW-1:0]                  sram_addr;
  logic [S*DW-1:0]                  sram_wdata;
  logic [S*DW-1:0]                  sram_rdata;
  logic [S-1:0]                     sram_we_n;
  logic [S-1:0]                     sram_oe_n;
  logic [`GFX_COLOR_W-1:0]          vga_red;
  logic [`GFX_COLOR_W-1:0]          vga_grn;
  logic [`GFX_COLOR_W-1:0]          vga_blu;
  logic                             vga_hsync;
  logic                             vga_vsync;
  logic                             hs_q;
  logic                             vs_q;
  logic [11:0]                      old_key;

  gfx_stripe_top u_gfx_stripe_top (.*);

  for (genvar i = 0; i < S; i++) begin : g_sram
    sram_model u_sram (
      .addr(sram_addr[i*AW +: AW]), .wdata(sram_wdata[i*DW +: DW]),
      .rdata(sram_rdata[i*DW +: DW]), .we_n(sram_we_n[i]), .oe_n(sram_oe_n[i])
    );
  end

  initial begin
    pixel_clk = 1'b0;
    forever #50 pixel_clk = ~pixel_clk;
  end

  // previous sync levels for edge detection
  always @(negedge pixel_clk) begin
    hs_q <= vga_hsync;
    vs_q <= vga_vsync;
  end

  initial begin
    #(WD_TIME);
    $display("timeout, the tests did not finish in 20 frame times");
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge pixel_clk);
    #10;
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge pixel_clk);
    #10;
    penable = 1'b1;
    @(posedge pixel_clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge pixel_clk);
    #10;
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge pixel_clk);
    #10;
    penable = 1'b1;
    // pslverr is combinational in the access cycle
    #40;
    err = pslverr;
    @(posedge pixel_clk);
    #10;
    data    = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic pixel_t pattern_pixel(input int x, input int y, input logic [11:0] key);
    pixel_t     p;
    logic [3:0] xs;
    logic [3:0] ys;
    xs = 4'(x);
    ys = 4'(y);
    p.red = xs ^ key[3:0];
    p.grn = ys ^ key[7:4];
    p.blu = 4'(xs + ys) ^ key[11:8];
    return p;
  endfunction

  task automatic wait_vsync_fall();
    do @(negedge pixel_clk); while (!(vs_q && !vga_vsync));
  endtask

  task automatic wait_hsync_fall();
    do @(negedge pixel_clk); while (!(hs_q && !vga_hsync));
  endtask

  // pixel 0 of a line comes H_WAIT cycles after the hsync fall
  task automatic scan_frame(input logic [11:0] key_a, input logic [11:0] key_b,
                            input bit accept_b);
    pixel_t act;
    pixel_t exp_a;
    int     n;
    wait_vsync_fall();
    for (int y = 0; y < `GFX_V_VISIBLE; y++) begin
      n = (y == 0) ? `GFX_V_SYNC + `GFX_V_BACK : 1;
      repeat (n) wait_hsync_fall();
      repeat (H_WAIT) @(negedge pixel_clk);
      for (int x = 0; x < H_SYNC_BEG; x++) begin
        if (x > 0) @(negedge pixel_clk);
        act = '{red: vga_red, grn: vga_grn, blu: vga_blu};
        if (x < `GFX_H_VISIBLE) begin
          exp_a = pattern_pixel(x, y, key_a);
          if (!(accept_b && act === pattern_pixel(x, y, key_b)))
            check_pixel($sformatf("vga pixel (%0d,%0d)", x, y), exp_a, act);
        end else begin
          check_pixel("vga blanking", '0, act);
        end
      end
    end
  endtask

  task automatic test_reset_values();
    logic [31:0] d;
    logic        err;
    check_bit("vga_hsync", 1'b1, vga_hsync);
    check_bit("vga_vsync", 1'b1, vga_vsync);
    check_pixel("vga color", '0, '{red: vga_red, grn: vga_grn, blu: vga_blu});
    rst_n = 1'b1;
    apb_read(REG_FRAMES, d, err);
    check_word("REG_FRAMES", 16'h0, d[15:0]);
    apb_read(REG_CTRL, d, err);
    check_word("REG_CTRL", 16'h0, d[15:0]);
    apb_read(REG_ERRS, d, err);
    check_word("REG_ERRS", 16'h0, d[15:0]);
    check_bit("pslverr", 1'b0, err);
    apb_read(8'h10, d, err);
    check_bit("pslverr", 1'b1, err);
  endtask

  task automatic test_single_frame();
    logic [11:0] key;
    key = 12'($urandom);
    apb_write(REG_KEY, 32'(key));
    apb_write(REG_CTRL, 32'h1);
    wait_vsync_fall();
    scan_frame(key, key, 1'b0);
    old_key = key;
  endtask

  task automatic test_continuous();
    logic [11:0] key;
    key = 12'($urandom);
    apb_write(REG_KEY, 32'(key));
    apb_write(REG_CTRL, 32'h3);
    scan_frame(old_key, key, 1'b1);
    wait_vsync_fall();
    wait_vsync_fall();
    scan_frame(key, key, 1'b0);
  endtask

  task automatic test_frame_count();
    logic [31:0] d0;
    logic [31:0] d1;
    logic        err;
    wait_vsync_fall();
    apb_read(REG_FRAMES, d0, err);
    repeat (3) wait_vsync_fall();
    apb_read(REG_FRAMES, d1, err);
    check_word("REG_FRAMES delta", 16'd3, d1[15:0] - d0[15:0]);
  endtask

  // starve the display for one visible line, one error per missed pixel
  task automatic test_error_count();
    logic [31:0] d;
    logic        err;
    apb_read(REG_ERRS, d, err);
    check_word("REG_ERRS", 16'h0, d[15:0]);
    wait_vsync_fall();
    repeat (`GFX_V_SYNC + `GFX_V_BACK + 1) wait_hsync_fall();
    force u_gfx_stripe_top.pix_empty = 1'b1;
    wait_hsync_fall();
    release u_gfx_stripe_top.pix_empty;
    apb_read(REG_ERRS, d, err);
    check_word("REG_ERRS", 16'(`GFX_H_VISIBLE), d[15:0]);
    apb_write(REG_ERRS, 32'h0);
    apb_read(REG_ERRS, d, err);
    check_word("REG_ERRS", 16'h0, d[15:0]);
  endtask

  initial begin
    void'($urandom(32'h579f532e));
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    old_key = '0;
    repeat (8) @(posedge pixel_clk);
    #10;
    test_reset_values();
    test_single_frame();
    test_continuous();
    test_frame_count();
    test_error_count();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: gfx_stripe_top.f
+incdir+.
gfx_stripe_pkg.sv
vga_timing.sv
pattern_writer.sv
pixel_fifo.sv
stripe_sram_ctrl.sv
gfx_apb_regs.sv
gfx_stripe_top.sv
sram_model.sv
gfx_stripe_checker.sv
gfx_stripe_tb.sv
